// File: rtl/fe_pkg.sv
package fe_pkg;

    localparam int unsigned XLEN = 32;

    // opcodes seen by predecode
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // link register
    localparam logic [4:0] REG_RA = 5'd1;

    //////////////////////////////
    // instruction views

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    //////////////////////////////
    // stage and back end traffic

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } fetch_pkt_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            taken;
    } bht_update_t;

endpackage

// File: rtl/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen #(
    parameter int unsigned                CREDITS  = 4,
    parameter logic [fe_pkg::XLEN-1:0]    RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // back end restart
    input  fe_pkg::redirect_t        redirect_i,

    // from predecode
    input  logic                     pred_redirect_valid_i,
    input  logic [fe_pkg::XLEN-1:0]  pred_target_i,
    input  logic                     squash_refund_i,

    // from decode
    input  logic                     credit_return_i,

    output logic [fe_pkg::XLEN-1:0]  rom_addr_o,
    output logic                     rom_en_o,
    output logic                     issue_valid_o,
    output logic [fe_pkg::XLEN-1:0]  issue_pc_o
);

    import fe_pkg::*;

    localparam int unsigned CW = $clog2(CREDITS + 1);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic [CW-1:0]   credit_q;
    logic [CW-1:0]   credit_d;
    logic            issue;

    // one fetch per cycle while a decode slot is free
    assign issue = (credit_q != '0);

    assign rom_addr_o    = pc_q;
    assign rom_en_o      = issue;
    assign issue_valid_o = issue;
    assign issue_pc_o    = pc_q;

    //////////////////////////////
    // next pc

    always_comb begin
        pc_d = pc_q;
        if (redirect_i.valid) begin
            pc_d = redirect_i.pc;
        end else if (pred_redirect_valid_i) begin
            pc_d = pred_target_i;
        end else if (issue) begin
            pc_d = pc_q + XLEN'(4);
        end
    end

    //////////////////////////////
    // credits

    // issue, refund and return may all land in one cycle
    always_comb begin
        credit_d = credit_q - CW'(issue) + CW'(squash_refund_i) + CW'(credit_return_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= RESET_PC;
            credit_q <= CW'(CREDITS);
        end else begin
            pc_q     <= pc_d;
            credit_q <= credit_d;
        end
    end

endmodule

// File: rtl/fe_predecode.sv
`timescale 1ns/1ps

module fe_predecode (
    input  logic                     clk,
    input  logic                     arst_n_i,

    input  logic                     issue_valid_i,
    input  logic [fe_pkg::XLEN-1:0]  issue_pc_i,
    input  fe_pkg::instr_u           rom_data_i,
    input  logic                     redirect_valid_i,

    // side tables
    input  logic                     bht_taken_i,
    input  logic [fe_pkg::XLEN-1:0]  ras_top_i,
    output logic [fe_pkg::XLEN-1:0]  bht_index_pc_o,
    output logic                     ras_push_o,
    output logic                     ras_pop_o,
    output logic [fe_pkg::XLEN-1:0]  ras_push_value_o,

    // back to the address stage
    output logic                     pred_redirect_valid_o,
    output logic [fe_pkg::XLEN-1:0]  pred_target_o,
    output logic                     squash_refund_o,

    output fe_pkg::fetch_pkt_t       fetch_pkt_o
);

    import fe_pkg::*;

    logic            stage_valid_q;
    logic            stage_killed_q;
    logic [XLEN-1:0] stage_pc_q;
    logic            live;
    logic            is_jal;
    logic            is_branch;
    logic            is_ret;
    logic            is_call;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] pc_plus4;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
    logic            pkt_valid_q;
    logic [XLEN-1:0] pkt_pc_q;
    instr_u          pkt_instr_q;
    logic            pkt_taken_q;
    logic [XLEN-1:0] pkt_target_q;

    // stage entry survives only if nothing younger-killing came along
    assign live            = stage_valid_q & ~stage_killed_q & ~redirect_valid_i;
    assign squash_refund_o = stage_valid_q & (stage_killed_q | redirect_valid_i);

    //////////////////////////////
    // partial decode

    assign is_jal    = (rom_data_i.j_fmt.opcode == OPC_JAL);
    assign is_branch = (rom_data_i.b_fmt.opcode == OPC_BRANCH);
    assign is_ret    = (rom_data_i.i_fmt.opcode == OPC_JALR) &&
                       (rom_data_i.i_fmt.rs1 == REG_RA) && (rom_data_i.i_fmt.rd == '0);
    assign is_call   = (is_jal && rom_data_i.j_fmt.rd == REG_RA) ||
                       ((rom_data_i.i_fmt.opcode == OPC_JALR) && rom_data_i.i_fmt.rd == REG_RA);

    assign j_imm = {{11{rom_data_i.j_fmt.imm_20}}, rom_data_i.j_fmt.imm_20,
                    rom_data_i.j_fmt.imm_19_12, rom_data_i.j_fmt.imm_11,
                    rom_data_i.j_fmt.imm_10_1, 1'b0};
    assign b_imm = {{19{rom_data_i.b_fmt.imm_12}}, rom_data_i.b_fmt.imm_12,
                    rom_data_i.b_fmt.imm_11, rom_data_i.b_fmt.imm_10_5,
                    rom_data_i.b_fmt.imm_4_1, 1'b0};

    assign pc_plus4 = stage_pc_q + XLEN'(4);

    // not taken means fall through to pc + 4
    always_comb begin
        pred_taken  = 1'b0;
        pred_target = pc_plus4;
        if (is_jal) begin
            pred_taken  = 1'b1;
            pred_target = stage_pc_q + j_imm;
        end else if (is_branch && bht_taken_i) begin
            pred_taken  = 1'b1;
            pred_target = stage_pc_q + b_imm;
        end else if (is_ret) begin
            pred_taken  = 1'b1;
            pred_target = ras_top_i;
        end
    end

    assign bht_index_pc_o        = stage_pc_q;
    assign ras_push_o            = live & is_call;
    assign ras_pop_o             = live & is_ret;
    assign ras_push_value_o      = pc_plus4;
    assign pred_redirect_valid_o = live & pred_taken;
    assign pred_target_o         = pred_target;

    //////////////////////////////
    // registers

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_valid_q  <= 1'b0;
            stage_killed_q <= 1'b0;
            pkt_valid_q    <= 1'b0;
        end else begin
            stage_valid_q  <= issue_valid_i;
            stage_killed_q <= redirect_valid_i | pred_redirect_valid_o;
            pkt_valid_q    <= live;
        end
    end

    always_ff @(posedge clk) begin
        stage_pc_q <= issue_pc_i;
        if (live) begin
            pkt_pc_q     <= stage_pc_q;
            pkt_instr_q  <= rom_data_i;
            pkt_taken_q  <= pred_taken;
            pkt_target_q <= pred_target;
        end
    end

    always_comb begin
        fetch_pkt_o.valid       = pkt_valid_q;
        fetch_pkt_o.pc          = pkt_pc_q;
        fetch_pkt_o.instr       = pkt_instr_q;
        fetch_pkt_o.pred_taken  = pkt_taken_q;
        fetch_pkt_o.pred_target = pkt_target_q;
    end

endmodule

// File: rtl/fe_branch_bht.sv
`timescale 1ns/1ps

module fe_branch_bht #(
    parameter int unsigned BHT_ENTRIES = 64
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    input  logic [fe_pkg::XLEN-1:0]  read_pc_i,
    input  fe_pkg::bht_update_t      update_i,

    output logic                     taken_o
);

    localparam int unsigned IDXW = (BHT_ENTRIES > 1) ? $clog2(BHT_ENTRIES) : 1;

    logic [1:0]      cnt_q [BHT_ENTRIES];
    logic [IDXW-1:0] rd_idx;
    logic [IDXW-1:0] upd_idx;
    logic [1:0]      upd_cur;
    logic [1:0]      upd_next;

    // word aligned pcs, skip bits 1:0
    assign rd_idx  = read_pc_i[IDXW+1:2];
    assign upd_idx = update_i.pc[IDXW+1:2];

    assign taken_o = cnt_q[rd_idx][1];

    // saturating step
    assign upd_cur = cnt_q[upd_idx];
    always_comb begin
        upd_next = upd_cur;
        if (update_i.taken && upd_cur != 2'b11) begin
            upd_next = upd_cur + 2'd1;
        end else if (!update_i.taken && upd_cur != 2'b00) begin
            upd_next = upd_cur - 2'd1;
        end
    end

    // all entries start weakly not taken
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_q[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            cnt_q[upd_idx] <= upd_next;
        end
    end

endmodule

// File: rtl/fe_ras.sv
`timescale 1ns/1ps

module fe_ras #(
    parameter int unsigned RAS_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    input  logic                     push_i,
    input  logic                     pop_i,
    input  logic [fe_pkg::XLEN-1:0]  push_value_i,

    output logic [fe_pkg::XLEN-1:0]  top_o
);

    import fe_pkg::*;

    localparam int unsigned PW = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

    logic [XLEN-1:0] stk_q [RAS_DEPTH];
    logic [PW-1:0]   tos_q;
    logic [PW-1:0]   tos_inc;
    logic [PW-1:0]   tos_dec;

    // wrap both ways, oldest entry gets overwritten on overflow
    assign tos_inc = (tos_q == PW'(RAS_DEPTH - 1)) ? '0 : tos_q + 1'b1;
    assign tos_dec = (tos_q == '0) ? PW'(RAS_DEPTH - 1) : tos_q - 1'b1;

    assign top_o = stk_q[tos_q];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tos_q <= '0;
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stk_q[i] <= '0;
            end
        end else begin
            case ({push_i, pop_i})
                2'b10: begin
                    tos_q        <= tos_inc;
                    stk_q[tos_inc] <= push_value_i;
                end
                2'b01: begin
                    // empty pop just walks onto a stale slot
                    tos_q <= tos_dec;
                end
                2'b11: begin
                    stk_q[tos_q] <= push_value_i;
                end
                default: begin
                    tos_q <= tos_q;
                end
            endcase
        end
    end

endmodule

// File: rtl/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend #(
    parameter int unsigned                CREDITS     = 4,
    parameter int unsigned                BHT_ENTRIES = 64,
    parameter int unsigned                RAS_DEPTH   = 4,
    parameter logic [fe_pkg::XLEN-1:0]    RESET_PC    = '0
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // instruction ROM
    output logic [fe_pkg::XLEN-1:0]  rom_addr_o,
    output logic                     rom_en_o,
    input  fe_pkg::instr_u           rom_data_i,

    // decode
    output fe_pkg::fetch_pkt_t       fetch_pkt_o,
    input  logic                     credit_return_i,

    // back end
    input  fe_pkg::redirect_t        redirect_i,
    input  fe_pkg::bht_update_t      bht_update_i
);

    import fe_pkg::*;

    logic            issue_valid;
    logic [XLEN-1:0] issue_pc;
    logic            pred_redirect_valid;
    logic [XLEN-1:0] pred_target;
    logic            squash_refund;
    logic [XLEN-1:0] bht_index_pc;
    logic            bht_taken;
    logic            ras_push;
    logic            ras_pop;
    logic [XLEN-1:0] ras_push_value;
    logic [XLEN-1:0] ras_top;

    //////////////////////////////
    // address stage

    fe_pc_gen #(
        .CREDITS  (CREDITS),
        .RESET_PC (RESET_PC)
    ) fe_pc_gen_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .redirect_i            (redirect_i),
        .pred_redirect_valid_i (pred_redirect_valid),
        .pred_target_i         (pred_target),
        .squash_refund_i       (squash_refund),
        .credit_return_i       (credit_return_i),
        .rom_addr_o            (rom_addr_o),
        .rom_en_o              (rom_en_o),
        .issue_valid_o         (issue_valid),
        .issue_pc_o            (issue_pc)
    );

    //////////////////////////////
    // predecode stage

    fe_predecode fe_predecode_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .issue_valid_i         (issue_valid),
        .issue_pc_i            (issue_pc),
        .rom_data_i            (rom_data_i),
        .redirect_valid_i      (redirect_i.valid),
        .bht_taken_i           (bht_taken),
        .ras_top_i             (ras_top),
        .bht_index_pc_o        (bht_index_pc),
        .ras_push_o            (ras_push),
        .ras_pop_o             (ras_pop),
        .ras_push_value_o      (ras_push_value),
        .pred_redirect_valid_o (pred_redirect_valid),
        .pred_target_o         (pred_target),
        .squash_refund_o       (squash_refund),
        .fetch_pkt_o           (fetch_pkt_o)
    );

    // side tables
    fe_branch_bht #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) fe_branch_bht_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .read_pc_i (bht_index_pc),
        .update_i  (bht_update_i),
        .taken_o   (bht_taken)
    );

    fe_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) fe_ras_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .push_i       (ras_push),
        .pop_i        (ras_pop),
        .push_value_i (ras_push_value),
        .top_o        (ras_top)
    );

endmodule

// File: tests/tb_fe_model.svh
`ifndef TB_FE_MODEL_SVH
`define TB_FE_MODEL_SVH

// reference model state
logic [31:0] lfsr;
logic [31:0] m_pc;
logic [1:0]  m_bht [BHT_N];
logic [31:0] m_ras [RAS_N];
int          m_tos;
int          checks;
int          errors;

// galois form, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

//////////////////////////////
// instruction encoders

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] branch_word(input logic [31:0] off);
    return {off[12], off[10:5], 5'd2, 5'd3, 3'b000, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] ret_word();
    return {12'd0, REG_RA, 3'b000, 5'd0, OPC_JALR};
endfunction

// addi with random fields
function automatic logic [31:0] filler_word();
    logic [31:0] v;
    v = take_bits(25);
    return {v[24:0], 7'b0010011};
endfunction

//////////////////////////////
// model of the predicted stream

task automatic reset_model();
    m_pc  = RESET_PC;
    m_tos = 0;
    for (int i = 0; i < BHT_N; i++) begin
        m_bht[i] = 2'b01;
    end
    for (int i = 0; i < RAS_N; i++) begin
        m_ras[i] = '0;
    end
endtask

task automatic train_counter(input logic [31:0] pc, input logic taken);
    int idx;
    idx = int'((pc >> 2) % BHT_N);
    if (taken && m_bht[idx] != 2'b11) begin
        m_bht[idx] = m_bht[idx] + 2'd1;
    end else if (!taken && m_bht[idx] != 2'b00) begin
        m_bht[idx] = m_bht[idx] - 2'd1;
    end
endtask

// next delivered packet, walks pc and return stack
task automatic predict_packet(output logic [31:0] pc, output logic [31:0] w,
                              output logic tk, output logic [31:0] tgt);
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    logic        is_ret;
    logic        is_call;
    pc      = m_pc;
    w       = rom[m_pc[9:2]];
    j_imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    b_imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    is_ret  = (w[6:0] == OPC_JALR) && (w[19:15] == REG_RA) && (w[11:7] == 5'd0);
    is_call = ((w[6:0] == OPC_JAL) || (w[6:0] == OPC_JALR)) && (w[11:7] == REG_RA);
    tk      = 1'b0;
    tgt     = m_pc + 32'd4;
    if (w[6:0] == OPC_JAL) begin
        tk  = 1'b1;
        tgt = m_pc + j_imm;
    end else if (w[6:0] == OPC_BRANCH && m_bht[(m_pc >> 2) % BHT_N][1]) begin
        tk  = 1'b1;
        tgt = m_pc + b_imm;
    end else if (is_ret) begin
        tk    = 1'b1;
        tgt   = m_ras[m_tos];
        m_tos = (m_tos + RAS_N - 1) % RAS_N;
    end
    if (is_call) begin
        m_tos        = (m_tos + 1) % RAS_N;
        m_ras[m_tos] = m_pc + 32'd4;
    end
    m_pc = tgt;
endtask

`endif

// File: tests/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;

    import fe_pkg::*;

    localparam int          CREDITS     = 4;
    localparam int          BHT_N       = 64;
    localparam int          RAS_N       = 4;
    localparam logic [31:0] RESET_PC    = 32'h0;
    localparam int          TOTAL_PKTS  = 40 + 5 * 80;
    localparam int          CYCLE_LIMIT = TOTAL_PKTS * 4 + 400;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] rom_addr_o;
    logic        rom_en_o;
    instr_u      rom_q = '0;
    fetch_pkt_t  fetch_pkt_o;
    logic        credit_return_i;
    redirect_t   redirect_i;
    bht_update_t bht_update_i;

    logic [31:0] rom [256];
    int          mode;
    int          held;
    int          max_held;
    int          got;
    int          test_cycles;
    int          cycles = 0;
    logic        pend_valid;
    logic [31:0] pend_pc;
    logic        pend_taken;

    `include "tb_fe_model.svh"

    fetch_frontend #(
        .CREDITS     (CREDITS),
        .BHT_ENTRIES (BHT_N),
        .RAS_DEPTH   (RAS_N),
        .RESET_PC    (RESET_PC)
    ) fetch_frontend_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .rom_addr_o      (rom_addr_o),
        .rom_en_o        (rom_en_o),
        .rom_data_i      (rom_q),
        .fetch_pkt_o     (fetch_pkt_o),
        .credit_return_i (credit_return_i),
        .redirect_i      (redirect_i),
        .bht_update_i    (bht_update_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // synchronous rom, data one cycle after enable
    always @(posedge clk) begin
        if (rom_en_o) begin
            rom_q <= rom[rom_addr_o[9:2]];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("ERROR run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // rom programs

    task automatic fill_rom(input int m);
        logic [31:0] pick;
        int          tgt;
        int          base;
        int          size;
        size = (m == 3) ? 16 : 32;
        for (int i = 0; i < 256; i++) begin
            rom[i] = filler_word();
        end
        if (m == 2) begin
            // main calls f1 then loops, f1 to f4 nest one level each
            rom[0] = jal_word(REG_RA, 32'd32);
            rom[1] = jal_word(5'd0, -32'sd4);
            for (int k = 1; k <= 4; k++) begin
                base = 8 * k + int'(take_bits(2));
                if (k < 4) begin
                    rom[base] = jal_word(REG_RA, (8 * (k + 1) - base) * 4);
                    base++;
                end
                rom[base] = ret_word();
            end
        end else if (m != 0) begin
            for (int i = 0; i < size - 1; i++) begin
                pick = take_bits(3);
                tgt  = int'(take_bits(5)) % size;
                if (m == 3 && pick[0]) begin
                    rom[i] = branch_word((tgt - i) * 4);
                end else if (m != 3 && pick == 32'd4) begin
                    rom[i] = jal_word(5'd0, (tgt - i) * 4);
                end else if (m != 3 && pick == 32'd5) begin
                    rom[i] = jal_word(REG_RA, (tgt - i) * 4);
                end else if (m != 3 && pick == 32'd6) begin
                    rom[i] = branch_word((tgt - i) * 4);
                end else if (m != 3 && pick == 32'd7) begin
                    rom[i] = ret_word();
                end
            end
            rom[size - 1] = jal_word(5'd0, -(size - 1) * 4);
        end
    endtask

    //////////////////////////////
    // one cycle of decode and back end

    task automatic step_cycle();
        logic [31:0] exp_pc;
        logic [31:0] exp_instr;
        logic        exp_taken;
        logic [31:0] exp_target;
        logic        return_ok;
        @(negedge clk);
        test_cycles++;
        if (fetch_pkt_o.valid) begin
            predict_packet(exp_pc, exp_instr, exp_taken, exp_target);
            check_value("fetch_pkt_o.pc", fetch_pkt_o.pc, exp_pc);
            check_value("fetch_pkt_o.instr", fetch_pkt_o.instr, exp_instr);
            check_value("fetch_pkt_o.pred_taken", {31'd0, fetch_pkt_o.pred_taken},
                        {31'd0, exp_taken});
            check_value("fetch_pkt_o.pred_target", fetch_pkt_o.pred_target, exp_target);
            held++;
            got++;
        end
        // every credit sits at decode, nothing may issue
        if (held == CREDITS) begin
            check_value("rom_en_o", {31'd0, rom_en_o}, 32'd0);
        end
        if (held > CREDITS) begin
            $display("ERROR %0d packets outstanding at decode, limit is %0d", held, CREDITS);
            errors++;
        end
        max_held = (held > max_held) ? held : max_held;
        // a counter write shows up two samples later
        if (pend_valid) begin
            train_counter(pend_pc, pend_taken);
        end
        pend_valid = 1'b0;
        return_ok = (mode != 4) || (test_cycles % 32 >= 12);
        credit_return_i = 1'b0;
        if (held > 0 && return_ok && (mode == 4 || take_bits(1) == 32'd1)) begin
            credit_return_i = 1'b1;
            held--;
        end
        bht_update_i = '0;
        if (mode == 3 && take_bits(1) == 32'd1) begin
            bht_update_i.valid = 1'b1;
            bht_update_i.pc    = take_bits(4) << 2;
            bht_update_i.taken = (take_bits(1) == 32'd1);
            pend_valid = 1'b1;
            pend_pc    = bht_update_i.pc;
            pend_taken = bht_update_i.taken;
        end
        redirect_i = '0;
        if (mode == 5 && take_bits(4) == 32'd0) begin
            redirect_i.valid = 1'b1;
            redirect_i.pc    = take_bits(5) << 2;
            m_pc             = redirect_i.pc;
        end
    endtask

    task automatic run_test(input int m, input string name, input int npkts);
        int errs_before;
        errs_before     = errors;
        mode            = m;
        arst_n_i        = 1'b0;
        credit_return_i = 1'b0;
        redirect_i      = '0;
        bht_update_i    = '0;
        held            = 0;
        max_held        = 0;
        got             = 0;
        test_cycles     = 0;
        pend_valid      = 1'b0;
        fill_rom(m);
        reset_model();
        repeat (8) @(negedge clk);
        arst_n_i = 1'b1;
        while (got < npkts) begin
            step_cycle();
        end
        if (m == 4) begin
            check_value("max_outstanding", max_held, CREDITS);
        end
        $display("test %0d %s: %0d packets, %0d errors", m + 1, name, got,
                 errors - errs_before);
    endtask

    initial begin
        lfsr            = 32'h1ada6533;
        arst_n_i        = 1'b0;
        credit_return_i = 1'b0;
        redirect_i      = '0;
        bht_update_i    = '0;
        checks          = 0;
        errors          = 0;
        run_test(0, "straight_line", 40);
        run_test(1, "jal_targets", 80);
        run_test(2, "call_return_nesting", 80);
        run_test(3, "bht_training", 80);
        run_test(4, "credit_backpressure", 80);
        run_test(5, "backend_redirect", 80);
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: fetch_frontend.f
+incdir+tests
rtl/fe_pkg.sv
rtl/fe_pc_gen.sv
rtl/fe_predecode.sv
rtl/fe_branch_bht.sv
rtl/fe_ras.sv
rtl/fetch_frontend.sv
tests/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch_frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fetch_frontend

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir obj_dir -f fetch_frontend.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
